/* hw/peak_pkg.sv */
`default_nettype none

package peak_pkg;

  // channel and list geometry
  localparam int channels   = 4;  // input streams
  localparam int num_peaks  = 4;  // entries kept per channel and frame

  // sample fields
  localparam int value_width = 16; // unsigned magnitude
  localparam int index_width = 8;  // frames up to 256 samples

  // result memory
  localparam int num_entries = channels * num_peaks; // one entry per channel and rank
  localparam int addr_width  = 4;                    // covers num_entries

  // collector sequencing
  typedef enum logic [1:0] {
    idle,   // waiting for every channel done
    write,  // one entry per cycle into memory
    finish  // peaks_ready pulse
  } collect_state_t;

endpackage

`default_nettype wire

/* hw/peak_channel.sv */
`default_nettype none

module peak_channel (
  input  wire                                                        process_clks,
  input  wire                                                        reset,
  input  wire                                                        sample_valid,
  input  wire                                                        sample_last,
  input  wire  [peak_pkg::value_width-1:0]                           sample_value,
  input  wire                                                        clear_done,
  output logic                                                       done,
  output logic [peak_pkg::num_peaks-1:0][peak_pkg::value_width-1:0] held_values,
  output logic [peak_pkg::num_peaks-1:0][peak_pkg::index_width-1:0] held_indices
);

  logic [peak_pkg::index_width-1:0]                           sample_index; // pos in frame
  logic [peak_pkg::num_peaks-1:0][peak_pkg::value_width-1:0] work_values;  // largest at 0
  logic [peak_pkg::num_peaks-1:0][peak_pkg::index_width-1:0] work_indices; // matching idx
  logic [peak_pkg::num_peaks-1:0]                             beats;        // strictly above
  logic [peak_pkg::num_peaks-1:0][peak_pkg::value_width-1:0] next_values;  // list after insert
  logic [peak_pkg::num_peaks-1:0][peak_pkg::index_width-1:0] next_indices;

  // compare against every slot at once
  always_comb begin
    for (int k = 0; k < peak_pkg::num_peaks; k++) begin
      beats[k] = sample_value > work_values[k]; // ties lose, keeps earlier index
    end
  end

  // beats is monotone over rank since the list is sorted descending:
  // the first set bit is the insert slot, everything below shifts down one
  always_comb begin
    next_values  = work_values;  // default no change
    next_indices = work_indices;
    if (beats[0]) begin
      next_values[0]  = sample_value; // new maximum
      next_indices[0] = sample_index;
    end
    for (int k = 1; k < peak_pkg::num_peaks; k++) begin
      if (beats[k-1]) begin
        next_values[k]  = work_values[k-1]; // shift down, tail entry drops
        next_indices[k] = work_indices[k-1];
      end else if (beats[k]) begin
        next_values[k]  = sample_value;     // insert point
        next_indices[k] = sample_index;
      end
    end
  end

  // working list, index counter, done flag
  always_ff @(posedge process_clks) begin
    if (reset) begin
      sample_index <= '0;
      work_values  <= '0; // zeros fill unused slots
      work_indices <= '0;
      done         <= 1'b0;
    end else begin
      if (clear_done) begin
        done <= 1'b0; // collector has copied the list
      end
      if (sample_valid) begin
        if (sample_last) begin
          sample_index <= '0;   // next frame starts at 0
          work_values  <= '0;
          work_indices <= '0;
          done         <= 1'b1; // set wins over clear
        end else begin
          sample_index <= sample_index + 1'b1;
          work_values  <= next_values;
          work_indices <= next_indices;
        end
      end
    end
  end

  // frozen copy for the collector, includes the last sample
  always_ff @(posedge process_clks) begin
    if (sample_valid && sample_last) begin
      held_values  <= next_values;
      held_indices <= next_indices;
    end
  end

endmodule

`default_nettype wire

/* hw/peak_collector.sv */
`default_nettype none

module peak_collector (
  input  wire                                 process_clks,
  input  wire                                 reset,
  input  wire  [peak_pkg::channels-1:0]       done,
  input  wire  [peak_pkg::channels-1:0][peak_pkg::num_peaks-1:0][peak_pkg::value_width-1:0]
                                              held_values,
  input  wire  [peak_pkg::channels-1:0][peak_pkg::num_peaks-1:0][peak_pkg::index_width-1:0]
                                              held_indices,
  output logic                                clear_done,
  output logic                                wr_en,
  output logic [peak_pkg::addr_width-1:0]     wr_addr,
  output logic [peak_pkg::value_width-1:0]    wr_value,
  output logic [peak_pkg::index_width-1:0]    wr_index,
  output logic                                peaks_ready
);

  peak_pkg::collect_state_t state;      // sequencer state
  logic                     all_done;   // every channel has a frozen list
  logic                     last_entry; // write address at final entry
  int unsigned              chan_sel;   // channel of current entry
  int unsigned              rank_sel;   // rank within that channel

  assign all_done   = &done;
  assign last_entry = (32'(wr_addr) == peak_pkg::num_entries - 1);

  // entry layout is channel major
  always_comb begin
    chan_sel = 32'(wr_addr) / peak_pkg::num_peaks;
    rank_sel = 32'(wr_addr) % peak_pkg::num_peaks;
  end

  assign wr_value = held_values[chan_sel][rank_sel];  // entry mux
  assign wr_index = held_indices[chan_sel][rank_sel];

  // idle -> write x num_entries -> finish -> idle
  always_ff @(posedge process_clks) begin
    if (reset) begin
      state   <= peak_pkg::idle;
      wr_addr <= '0;
    end else begin
      case (state)
        peak_pkg::idle: begin
          if (all_done) begin
            state   <= peak_pkg::write;
            wr_addr <= '0; // first entry next cycle
          end
        end
        peak_pkg::write: begin
          if (last_entry) begin
            state <= peak_pkg::finish;
          end else begin
            wr_addr <= wr_addr + 1'b1;
          end
        end
        peak_pkg::finish: begin
          state <= peak_pkg::idle; // done flags already cleared here
        end
        default: begin
          state <= peak_pkg::idle;
        end
      endcase
    end
  end

  assign wr_en       = (state == peak_pkg::write);
  assign clear_done  = wr_en && last_entry;          // with final write
  assign peaks_ready = (state == peak_pkg::finish);  // single cycle

endmodule

`default_nettype wire

/* hw/result_ram.sv */
`default_nettype none

module result_ram (
  input  wire                              process_clks,
  input  wire                              wr_en,
  input  wire  [peak_pkg::addr_width-1:0]  wr_addr,
  input  wire  [peak_pkg::value_width-1:0] wr_value,
  input  wire  [peak_pkg::index_width-1:0] wr_index,
  input  wire  [peak_pkg::addr_width-1:0]  rd_addr,
  output logic [peak_pkg::value_width-1:0] rd_value,
  output logic [peak_pkg::index_width-1:0] rd_index
);

  // value in the upper field, index below
  logic [peak_pkg::value_width+peak_pkg::index_width-1:0] mem [peak_pkg::num_entries];

  always_ff @(posedge process_clks) begin
    if (wr_en) begin
      mem[wr_addr] <= {wr_value, wr_index}; // collector port
    end
  end

  // host port, one cycle latency, old data on collision
  always_ff @(posedge process_clks) begin
    {rd_value, rd_index} <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* hw/peak_top.sv */
`default_nettype none

module peak_top (
  input  wire                                                       process_clks,
  input  wire                                                       reset,
  input  wire  [peak_pkg::channels-1:0]                             sample_valid,
  input  wire  [peak_pkg::channels-1:0]                             sample_last,
  input  wire  [peak_pkg::channels-1:0][peak_pkg::value_width-1:0] sample_value,
  input  wire  [peak_pkg::addr_width-1:0]                           rd_addr,
  output logic                                                      peaks_ready,
  output logic [peak_pkg::value_width-1:0]                          rd_value,
  output logic [peak_pkg::index_width-1:0]                          rd_index
);

  logic [peak_pkg::channels-1:0] done;       // per channel frame end
  logic [peak_pkg::channels-1:0][peak_pkg::num_peaks-1:0][peak_pkg::value_width-1:0]
                                 held_values;
  logic [peak_pkg::channels-1:0][peak_pkg::num_peaks-1:0][peak_pkg::index_width-1:0]
                                 held_indices;
  logic                          clear_done; // broadcast to all channels
  logic                          wr_en;
  logic [peak_pkg::addr_width-1:0]  wr_addr;
  logic [peak_pkg::value_width-1:0] wr_value;
  logic [peak_pkg::index_width-1:0] wr_index;

  for (genvar c = 0; c < peak_pkg::channels; c++) begin : g_chan
    peak_channel u_peak_channel (
      .process_clks (process_clks),
      .reset        (reset),
      .sample_valid (sample_valid[c]),
      .sample_last  (sample_last[c]),
      .sample_value (sample_value[c]),
      .clear_done   (clear_done),
      .done         (done[c]),
      .held_values  (held_values[c]),
      .held_indices (held_indices[c])
    );
  end

  peak_collector u_peak_collector (
    .process_clks (process_clks),
    .reset        (reset),
    .done         (done),
    .held_values  (held_values),
    .held_indices (held_indices),
    .clear_done   (clear_done),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_value     (wr_value),
    .wr_index     (wr_index),
    .peaks_ready  (peaks_ready)
  );

  result_ram u_result_ram (
    .process_clks (process_clks),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_value     (wr_value),
    .wr_index     (wr_index),
    .rd_addr      (rd_addr),
    .rd_value     (rd_value),
    .rd_index     (rd_index)
  );

endmodule

`default_nettype wire

/* dv/clk_gen.sv */
`default_nettype none

module clk_gen (
  output logic process_clks,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    process_clks = 1'b0;
    forever #2 process_clks = ~process_clks; // 4 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge process_clks); // two sampled reset edges
    @(negedge process_clks);
    reset = 1'b0; // release away from the active edge
  end

endmodule

`default_nettype wire

/* dv/peak_assertions.sv */
`default_nettype none

module peak_assertions (
  input wire                           process_clks,
  input wire                           reset,
  input wire peak_pkg::collect_state_t state,
  input wire [peak_pkg::channels-1:0]  done,
  input wire                           clear_done,
  input wire                           wr_en,
  input wire                           peaks_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  int assert_errors = 0; // read by the testbench monitor

  a_ready_pulse : assert property (@(posedge process_clks) disable iff (reset)
    peaks_ready |=> !peaks_ready) else begin
    $error("peaks_ready high for more than one cycle");
    assert_errors++;
  end

  // idle holds off writes until every list is frozen
  a_idle_no_write : assert property (@(posedge process_clks) disable iff (reset)
    (state == peak_pkg::idle) && !(&done) |=> !wr_en) else begin
    $error("wr_en high after idle without every channel done");
    assert_errors++;
  end

  // ready only right after the final write
  a_ready_not_write : assert property (@(posedge process_clks) disable iff (reset)
    peaks_ready |-> !wr_en && $past(clear_done)) else begin
    $error("peaks_ready with wr_en or not after the final write");
    assert_errors++;
  end

endmodule

bind peak_collector peak_assertions u_peak_assertions (
  .process_clks (process_clks),
  .reset        (reset),
  .state        (state),
  .done         (done),
  .clear_done   (clear_done),
  .wr_en        (wr_en),
  .peaks_ready  (peaks_ready)
);

`default_nettype wire

/* dv/tb_peak_top.sv */
`default_nettype none

module tb_peak_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int entry_w   = peak_pkg::value_width + peak_pkg::index_width;
  localparam int beat_w    = peak_pkg::value_width + 2; // valid, last, value
  localparam int max_beats = 128;
  localparam int max_frame = 256;
  localparam int max_coll  = 8;
  localparam int num_coll  = 6;
  localparam int frame_cycles   = 167; // longest channel per test: 20+12+3+57+75
  localparam int timeout_cycles = frame_cycles + 40 * num_coll + 10; // 10 for reset

  logic                                                      process_clks;
  logic                                                      reset;
  logic [peak_pkg::channels-1:0]                             sample_valid;
  logic [peak_pkg::channels-1:0]                             sample_last;
  logic [peak_pkg::channels-1:0][peak_pkg::value_width-1:0] sample_value;
  logic [peak_pkg::addr_width-1:0]                           rd_addr;
  logic                                                      peaks_ready;
  logic [peak_pkg::value_width-1:0]                          rd_value;
  logic [peak_pkg::index_width-1:0]                          rd_index;

  logic [15:0]              lfsr_state = 16'd15231;
  logic [beat_w-1:0]        beat_buf [peak_pkg::channels][max_beats]; // per cycle drive
  int                       beat_len [peak_pkg::channels];
  logic [peak_pkg::value_width-1:0] frame_buf [peak_pkg::channels][max_frame];
  int                       frame_len [peak_pkg::channels];   // samples so far in frame
  int                       frame_count [peak_pkg::channels]; // frames ended
  logic [peak_pkg::num_peaks-1:0][entry_w-1:0] exp_peaks [max_coll][peak_pkg::channels];
  int                       checked = 0;     // collections compared
  int                       cycle_count = 0;
  int                       assert_errors;

  assign assert_errors = u_peak_top.u_peak_collector.u_peak_assertions.assert_errors;

  clk_gen u_clk_gen (
    .process_clks (process_clks),
    .reset        (reset)
  );

  peak_top u_peak_top (
    .process_clks (process_clks),
    .reset        (reset),
    .sample_valid (sample_valid),
    .sample_last  (sample_last),
    .sample_value (sample_value),
    .rd_addr      (rd_addr),
    .peaks_ready  (peaks_ready),
    .rd_value     (rd_value),
    .rd_index     (rd_index)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state); // one step per bit
      r = (r << 1) | lfsr_state[0];
    end
    return r;
  endfunction

  // selection over the recorded frame: value desc, earlier index on ties
  function automatic logic [peak_pkg::num_peaks-1:0][entry_w-1:0] ref_peaks(input int ch);
    logic [peak_pkg::num_peaks-1:0][entry_w-1:0] res;
    bit taken [max_frame];
    int best;
    res = '0; // unused ranks stay zero
    for (int i = 0; i < max_frame; i++) taken[i] = 1'b0;
    for (int r = 0; r < peak_pkg::num_peaks; r++) begin
      best = -1;
      for (int i = 0; i < frame_len[ch]; i++) begin
        if (!taken[i] && frame_buf[ch][i] != 0 &&
            (best < 0 || frame_buf[ch][i] > frame_buf[ch][best])) begin
          best = i; // strict compare keeps first of equals
        end
      end
      if (best >= 0) begin
        taken[best] = 1'b1;
        res[r] = {frame_buf[ch][best], peak_pkg::index_width'(best)};
      end
    end
    return res;
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic add_beat(input int ch, input logic valid, input logic last,
                          input int unsigned value);
    beat_buf[ch][beat_len[ch]] = {valid, last, value[peak_pkg::value_width-1:0]};
    beat_len[ch]++;
  endtask

  task automatic add_idle(input int ch, input int n);
    for (int i = 0; i < n; i++) add_beat(ch, 1'b0, 1'b0, 0);
  endtask

  task automatic add_random(input int ch, input int n, input logic end_frame);
    for (int i = 0; i < n; i++) begin
      add_beat(ch, 1'b1, end_frame && (i == n - 1), rand_bits(peak_pkg::value_width));
    end
  endtask

  task automatic record_sample(input int ch, input logic [peak_pkg::value_width-1:0] v,
                               input logic last);
    frame_buf[ch][frame_len[ch]] = v;
    frame_len[ch]++;
    if (last) begin
      exp_peaks[frame_count[ch]][ch] = ref_peaks(ch); // expected for that collection
      frame_count[ch]++;
      frame_len[ch] = 0;
    end
  endtask

  // plays all channel beat lists side by side, one beat per falling edge
  task automatic run_beats();
    int longest;
    logic [beat_w-1:0] b;
    longest = 0;
    for (int c = 0; c < peak_pkg::channels; c++) begin
      if (beat_len[c] > longest) longest = beat_len[c];
    end
    for (int t = 0; t < longest; t++) begin
      @(negedge process_clks);
      for (int c = 0; c < peak_pkg::channels; c++) begin
        b = (t < beat_len[c]) ? beat_buf[c][t] : '0;
        sample_valid[c] = b[beat_w-1];
        sample_last[c]  = b[beat_w-2];
        sample_value[c] = b[peak_pkg::value_width-1:0];
        if (b[beat_w-1]) record_sample(c, b[peak_pkg::value_width-1:0], b[beat_w-2]);
      end
    end
    @(negedge process_clks);
    sample_valid = '0;
    sample_last  = '0;
    for (int c = 0; c < peak_pkg::channels; c++) beat_len[c] = 0;
  endtask

  task automatic wait_checks(input int n);
    wait (checked >= n); // timeout guards this
    @(negedge process_clks);
  endtask

  task automatic read_results(input int coll);
    logic [entry_w-1:0] exp;
    rd_addr = '0;
    for (int a = 0; a < peak_pkg::num_entries; a++) begin
      @(negedge process_clks); // data for a is registered now
      exp = exp_peaks[coll][a / peak_pkg::num_peaks][a % peak_pkg::num_peaks];
      check_equal("rd_value", rd_value, exp[peak_pkg::index_width +: peak_pkg::value_width]);
      check_equal("rd_index", rd_index, exp[peak_pkg::index_width-1:0]);
      rd_addr = peak_pkg::addr_width'(a + 1);
    end
  endtask

  initial begin : compare_results
    wait (reset == 1'b0);
    forever begin
      @(negedge process_clks);
      if (peaks_ready) begin
        for (int c = 0; c < peak_pkg::channels; c++) begin
          if (frame_count[c] <= checked) begin
            $display("peaks_ready rose before channel %0d ended its frame", c);
            abort_run();
          end
        end
        read_results(checked);
        checked++;
      end
    end
  end

  always @(posedge process_clks) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      $display("timeout after %0d cycles, collections did not complete", cycle_count);
      abort_run();
    end
  end

  always @(negedge process_clks) begin
    if (assert_errors != 0) begin
      $display("a collector assertion failed");
      abort_run();
    end
  end

  initial begin : stimulus
    int unsigned tie_vals [7] = '{3, 7, 7, 2, 7, 7, 9};
    sample_valid = '0;
    sample_last  = '0;
    sample_value = '0;
    rd_addr      = '0;
    for (int c = 0; c < peak_pkg::channels; c++) begin
      beat_len[c]    = 0;
      frame_len[c]   = 0;
      frame_count[c] = 0;
    end
    wait (reset == 1'b0);
    @(negedge process_clks);

    for (int c = 0; c < peak_pkg::channels; c++) add_random(c, 20, 1'b1); // random frames
    run_beats();
    wait_checks(1);

    for (int i = 0; i < 6; i++) add_beat(0, 1'b1, i == 5, 5);           // all equal
    for (int i = 0; i < 7; i++) add_beat(1, 1'b1, i == 6, tie_vals[i]);
    for (int i = 0; i < 12; i++) add_beat(2, 1'b1, i == 11, rand_bits(2) + 1);
    for (int i = 0; i < 5; i++) add_beat(3, 1'b1, i == 4, (i == 3) ? 200 : 100);
    run_beats();
    wait_checks(2);

    add_random(0, 1, 1'b1); // short frames
    add_random(1, 2, 1'b1);
    add_random(2, 3, 1'b1);
    add_beat(3, 1'b1, 1'b0, 0); // zeros must not take a slot
    add_beat(3, 1'b1, 1'b0, 40);
    add_beat(3, 1'b1, 1'b1, 0);
    run_beats();
    wait_checks(3);

    add_random(0, 10, 1'b1); // staggered frame ends
    add_idle(1, 15);
    add_random(1, 12, 1'b1);
    add_idle(2, 30);
    for (int i = 0; i < 12; i++) begin
      add_beat(2, 1'b1, i == 11, rand_bits(peak_pkg::value_width));
      add_idle(2, 1); // gapped valid
    end
    add_idle(3, 45);
    add_random(3, 12, 1'b1);
    run_beats();
    wait_checks(4);

    for (int c = 0; c < peak_pkg::channels; c++) begin
      add_random(c, 20, 1'b1);
      add_random(c, 50, 1'b0); // next frame during collection and readout
    end
    run_beats();
    wait_checks(5);
    for (int c = 0; c < peak_pkg::channels; c++) add_random(c, 5, 1'b1);
    run_beats();
    wait_checks(6);

    if (assert_errors == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("a collector assertion failed");
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* src.f */
hw/peak_pkg.sv
hw/peak_channel.sv
hw/peak_collector.sv
hw/result_ram.sv
hw/peak_top.sv
dv/clk_gen.sv
dv/peak_assertions.sv
dv/tb_peak_top.sv

/* Bender.yml */
package:
  name: peak_finder

sources:
  - files:
      - hw/peak_pkg.sv
      - hw/peak_channel.sv
      - hw/peak_collector.sv
      - hw/result_ram.sv
      - hw/peak_top.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/peak_assertions.sv
      - dv/tb_peak_top.sv
